// ==== write_guard_pkg.sv ====
// Shared widths, types and bus structs for the AXI write-channel watchdog.
// Every design file imports this package in its module header.

package write_guard_pkg;

  // Tracking capacity and field widths
  localparam int unsigned MAX_TXNS  = 4;
  localparam int unsigned TXN_IDX_W = 2;
  localparam int unsigned ID_W      = 4;
  localparam int unsigned LEN_W     = 8;
  localparam int unsigned CNT_W     = 12;
  // Wide enough for a 12-bit unit budget times 256 beats
  localparam int unsigned WBUD_W    = 20;

  // Clocks per watchdog tick
  localparam int unsigned PRESCALE_DIV = 4;
  localparam int unsigned PRESCALE_W   = $clog2(PRESCALE_DIV);

  typedef logic [ID_W-1:0]      txn_id_t;
  typedef logic [LEN_W-1:0]     burst_len_t;
  typedef logic [CNT_W-1:0]     tick_cnt_t;
  typedef logic [WBUD_W-1:0]    data_budget_t;
  typedef logic [TXN_IDX_W-1:0] slot_idx_t;

  // Lifecycle of one tracked write transaction
  typedef enum logic [1:0] {
    SLOT_FREE = 2'd0,
    SLOT_ADDR = 2'd1,
    SLOT_DATA = 2'd2,
    SLOT_RESP = 2'd3
  } slot_phase_e;

  // Signals driven by the bus master
  typedef struct packed {
    logic       aw_valid;
    txn_id_t    aw_id;
    burst_len_t aw_len;
    logic       w_valid;
    logic       w_last;
    logic       b_ready;
  } wr_req_t;

  // Signals driven by the bus slave
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    txn_id_t b_id;
  } wr_rsp_t;

  // Phase budgets in ticks, data budget is per beat
  typedef struct packed {
    tick_cnt_t aw_budget;
    tick_cnt_t w_unit_budget;
    tick_cnt_t b_budget;
  } guard_budget_t;

  typedef struct packed {
    logic aw_timeout;
    logic w_timeout;
    logic b_timeout;
    logic unwanted_b;
  } fault_cause_t;

endpackage

// ==== tick_prescaler.sv ====
// Free-running clock divider for the watchdog time base.
// Emits a single-cycle tick every PRESCALE_DIV clocks.

`timescale 1ns/10ps

module tick_prescaler import write_guard_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic tick_o
);

  logic [PRESCALE_W-1:0] div_cnt_q;

  // Tick is registered so the first one lands PRESCALE_DIV cycles after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_cnt_q <= PRESCALE_W'(PRESCALE_DIV - 1);
      tick_o    <= 1'b0;
    end else begin
      tick_o <= (div_cnt_q == '0);
      if (div_cnt_q == '0) begin
        div_cnt_q <= PRESCALE_W'(PRESCALE_DIV - 1);
      end else begin
        div_cnt_q <= div_cnt_q - 1'b1;
      end
    end
  end

endmodule

// ==== txn_slot.sv ====
// One tracked write transaction: phase FSM, tick counter and stored ID.
// The tracker drives at most one done strobe per slot and cycle.
// The data budget is scaled by the burst length at allocation.

`timescale 1ns/10ps

module txn_slot import write_guard_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         alloc_i,
  input  logic         addr_done_i,
  input  logic         data_done_i,
  input  logic         resp_done_i,
  input  logic         abort_i,
  input  logic         tick_i,
  input  txn_id_t      aw_id_i,
  input  burst_len_t   aw_len_i,
  input  tick_cnt_t    w_unit_budget_i,
  output slot_phase_e  phase_o,
  output txn_id_t      id_o,
  output tick_cnt_t    count_o,
  output data_budget_t data_budget_o
);

  slot_phase_e  phase_q, phase_d;
  tick_cnt_t    count_q;
  txn_id_t      id_q;
  data_budget_t budget_q;

  always_comb begin
    phase_d = phase_q;
    if (abort_i) begin
      phase_d = SLOT_FREE;
    end else begin
      case (phase_q)
        SLOT_FREE: begin
          // AW may handshake in the same cycle the slot is taken
          if (alloc_i) begin
            phase_d = addr_done_i ? SLOT_DATA : SLOT_ADDR;
          end
        end
        SLOT_ADDR: begin
          if (addr_done_i) begin
            phase_d = SLOT_DATA;
          end
        end
        SLOT_DATA: begin
          if (data_done_i) begin
            phase_d = SLOT_RESP;
          end
        end
        SLOT_RESP: begin
          if (resp_done_i) begin
            phase_d = SLOT_FREE;
          end
        end
        default: phase_d = SLOT_FREE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= SLOT_FREE;
      count_q <= '0;
    end else begin
      phase_q <= phase_d;
      // Restart on every phase entry, saturate instead of wrapping
      if (phase_d != phase_q) begin
        count_q <= '0;
      end else if (tick_i && (phase_q != SLOT_FREE) && (count_q != '1)) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Captured transaction attributes
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      id_q     <= aw_id_i;
      budget_q <= data_budget_t'(w_unit_budget_i) * (data_budget_t'(aw_len_i) + 1'b1);
    end
  end

  assign phase_o       = phase_q;
  assign id_o          = id_q;
  assign count_o       = count_q;
  assign data_budget_o = budget_q;

endmodule

// ==== txn_tracker.sv ====
// Follows in-order write transactions across all slots.
// Three circular pointers name the slot waiting for AW, the oldest one in
// data and the oldest one awaiting B. Overruns are reported combinationally.

`timescale 1ns/10ps

module txn_tracker import write_guard_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          tick_i,
  input  logic          abort_i,
  input  wr_req_t       req_i,
  input  wr_rsp_t       rsp_i,
  input  guard_budget_t budget_i,
  output fault_cause_t  fault_now_o
);

  slot_phase_e  slot_phase [MAX_TXNS];
  txn_id_t      slot_id    [MAX_TXNS];
  tick_cnt_t    slot_cnt   [MAX_TXNS];
  data_budget_t slot_wbud  [MAX_TXNS];

  logic [MAX_TXNS-1:0] alloc, addr_done, data_done, resp_done;

  slot_idx_t addr_ptr_q, data_ptr_q, resp_ptr_q;

  logic aw_hs, w_last_hs, b_hs;
  logic alloc_en, addr_step, data_step, resp_match, resp_step;

  // Handshakes as seen on the bus
  assign aw_hs     = req_i.aw_valid & rsp_i.aw_ready;
  assign w_last_hs = req_i.w_valid & rsp_i.w_ready & req_i.w_last;
  assign b_hs      = rsp_i.b_valid & req_i.b_ready;

  // Only the slot at the address pointer can be in SLOT_ADDR
  assign alloc_en  = req_i.aw_valid && (slot_phase[addr_ptr_q] == SLOT_FREE);
  assign addr_step = aw_hs && (alloc_en || (slot_phase[addr_ptr_q] == SLOT_ADDR));
  assign data_step = w_last_hs && (slot_phase[data_ptr_q] == SLOT_DATA);

  assign resp_match = (slot_phase[resp_ptr_q] == SLOT_RESP) &&
                      (slot_id[resp_ptr_q] == rsp_i.b_id);
  assign resp_step  = b_hs && resp_match;

  always_comb begin
    for (int i = 0; i < MAX_TXNS; i++) begin
      alloc[i]     = alloc_en  && (addr_ptr_q == slot_idx_t'(i));
      addr_done[i] = addr_step && (addr_ptr_q == slot_idx_t'(i));
      data_done[i] = data_step && (data_ptr_q == slot_idx_t'(i));
      resp_done[i] = resp_step && (resp_ptr_q == slot_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ptr_q <= '0;
      data_ptr_q <= '0;
      resp_ptr_q <= '0;
    end else if (abort_i) begin
      // Every slot is freed, so the order restarts from slot zero
      addr_ptr_q <= '0;
      data_ptr_q <= '0;
      resp_ptr_q <= '0;
    end else begin
      if (addr_step) begin
        addr_ptr_q <= addr_ptr_q + 1'b1;
      end
      if (data_step) begin
        data_ptr_q <= data_ptr_q + 1'b1;
      end
      if (resp_step) begin
        resp_ptr_q <= resp_ptr_q + 1'b1;
      end
    end
  end

  for (genvar g = 0; g < MAX_TXNS; g++) begin : gen_slot
    txn_slot u_slot (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .alloc_i         (alloc[g]),
      .addr_done_i     (addr_done[g]),
      .data_done_i     (data_done[g]),
      .resp_done_i     (resp_done[g]),
      .abort_i         (abort_i),
      .tick_i          (tick_i),
      .aw_id_i         (req_i.aw_id),
      .aw_len_i        (req_i.aw_len),
      .w_unit_budget_i (budget_i.w_unit_budget),
      .phase_o         (slot_phase[g]),
      .id_o            (slot_id[g]),
      .count_o         (slot_cnt[g]),
      .data_budget_o   (slot_wbud[g])
    );
  end

  // Each slot is checked against the budget of its current phase
  always_comb begin
    fault_now_o = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      case (slot_phase[i])
        SLOT_ADDR: begin
          if (slot_cnt[i] > budget_i.aw_budget) begin
            fault_now_o.aw_timeout = 1'b1;
          end
        end
        SLOT_DATA: begin
          if (data_budget_t'(slot_cnt[i]) > slot_wbud[i]) begin
            fault_now_o.w_timeout = 1'b1;
          end
        end
        SLOT_RESP: begin
          if (slot_cnt[i] > budget_i.b_budget) begin
            fault_now_o.b_timeout = 1'b1;
          end
        end
        default: ;
      endcase
    end
    // B with nothing outstanding or with the wrong ID
    fault_now_o.unwanted_b = b_hs && !resp_match;
  end

endmodule

// ==== fault_reporter.sv ====
// Turns detected faults into an abort, an interrupt pulse and a held
// reset request with its cause flags. System software clears them.

`timescale 1ns/10ps

module fault_reporter import write_guard_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         reset_clear_i,
  input  fault_cause_t fault_now_i,
  output logic         abort_o,
  output logic         irq_o,
  output logic         reset_req_o,
  output fault_cause_t fault_o
);

  fault_cause_t cause_q;
  logic         reset_req_q;
  logic         irq_q;

  // Any fault aborts all tracked transactions in the same cycle
  assign abort_o = |fault_now_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cause_q     <= '0;
      reset_req_q <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      irq_q <= abort_o;
      // A new fault takes priority over a clear request
      if (abort_o) begin
        cause_q     <= cause_q | fault_now_i;
        reset_req_q <= 1'b1;
      end else if (reset_clear_i) begin
        cause_q     <= '0;
        reset_req_q <= 1'b0;
      end
    end
  end

  assign irq_o       = irq_q;
  assign reset_req_o = reset_req_q;
  assign fault_o     = cause_q;

endmodule

// ==== write_guard.sv ====
// Top level of the AXI write-channel watchdog.
// Observes the write channels passively and raises a reset request and
// an interrupt when a phase budget is exceeded or a stray B appears.

`timescale 1ns/10ps

module write_guard import write_guard_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          reset_clear_i,
  input  wr_req_t       req_i,
  input  wr_rsp_t       rsp_i,
  input  guard_budget_t budget_i,
  output logic          irq_o,
  output logic          reset_req_o,
  output fault_cause_t  fault_o
);

  logic         tick;
  logic         abort;
  fault_cause_t fault_now;

  tick_prescaler u_prescaler (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tick_o (tick)
  );

  txn_tracker u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tick_i      (tick),
    .abort_i     (abort),
    .req_i       (req_i),
    .rsp_i       (rsp_i),
    .budget_i    (budget_i),
    .fault_now_o (fault_now)
  );

  fault_reporter u_reporter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reset_clear_i (reset_clear_i),
    .fault_now_i   (fault_now),
    .abort_o       (abort),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .fault_o       (fault_o)
  );

endmodule

// ==== tb_write_guard.sv ====
// Testbench for the AXI write-channel watchdog.
// Reads transactions from write_guard_patterns.txt, plays master and slave on
// the write channels and checks irq_o, reset_req_o and fault_o per pattern.

`timescale 1ns/10ps

module tb_write_guard import write_guard_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int GROUP_MAX  = 3;
  localparam logic [7:0] NO_ADDR = 8'hff;

  // One line of the pattern file
  typedef struct packed {
    txn_id_t      id;
    burst_len_t   len;
    logic [7:0]   aw_delay;
    logic [7:0]   w_delay;
    logic [7:0]   b_delay;
    txn_id_t      resp_id;
    fault_cause_t cause;
  } pattern_t;

  logic          clk;
  logic          rst_n;
  logic          reset_clear;
  wr_req_t       req;
  wr_rsp_t       rsp;
  guard_budget_t budget;
  logic          irq;
  logic          reset_req;
  fault_cause_t  fault;

  pattern_t            pats[$];
  logic [MAX_TXNS-1:0] aw_done;
  logic [MAX_TXNS-1:0] w_done;
  int                  irq_total;
  int                  limit_cycles;
  logic [31:0]         lfsr;

  write_guard dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .reset_clear_i (reset_clear),
    .req_i         (req),
    .rsp_i         (rsp),
    .budget_i      (budget),
    .irq_o         (irq),
    .reset_req_o   (reset_req),
    .fault_o       (fault)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Counts cycles with irq high, so one pulse adds exactly one
  initial irq_total = 0;
  always @(posedge clk) begin
    if (irq) begin
      irq_total <= irq_total + 1;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic fault_cause_t cause_from_name(input string name);
    fault_cause_t c;
    c = '0;
    if (name == "aw") c.aw_timeout = 1'b1;
    else if (name == "w") c.w_timeout = 1'b1;
    else if (name == "b") c.b_timeout = 1'b1;
    else if (name == "unwanted") c.unwanted_b = 1'b1;
    return c;
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED time %0t signal %s got %0h expected %0h", $time, sig, got, exp);
      abort_run();
    end
  endtask

  // Plays n transactions starting at pattern first, AW, W and B overlapped.
  // A W or B phase expected to overrun is withheld along with every later phase
  // An AW stall still ends in its handshake so the re-tracked W and B follow
  task run_group(input int first, input int n);
    int ka;
    int kw;
    int kb;
    aw_done = '0;
    w_done  = '0;
    fork
      begin
        for (ka = 0; ka < n; ka++) begin
          if (pats[first + ka].aw_delay != NO_ADDR) begin
            @(posedge clk);
            req.aw_valid <= 1'b1;
            req.aw_id    <= pats[first + ka].id;
            req.aw_len   <= pats[first + ka].len;
            repeat (pats[first + ka].aw_delay) @(posedge clk);
            rsp.aw_ready <= 1'b1;
            @(posedge clk);
            req.aw_valid <= 1'b0;
            rsp.aw_ready <= 1'b0;
          end
          aw_done[ka] = 1'b1;
        end
      end
      begin
        for (kw = 0; kw < n; kw++) begin
          wait (aw_done[kw]);
          if (pats[first + kw].aw_delay != NO_ADDR) begin
            repeat (pats[first + kw].w_delay) @(posedge clk);
            if (!pats[first + kw].cause.w_timeout) begin
              req.w_valid <= 1'b1;
              req.w_last  <= 1'b1;
              rsp.w_ready <= 1'b1;
              @(posedge clk);
              req.w_valid <= 1'b0;
              req.w_last  <= 1'b0;
              rsp.w_ready <= 1'b0;
            end
          end
          w_done[kw] = 1'b1;
        end
      end
      begin
        for (kb = 0; kb < n; kb++) begin
          wait (w_done[kb]);
          if (!pats[first + kb].cause.w_timeout) begin
            repeat (pats[first + kb].b_delay) @(posedge clk);
            if (!pats[first + kb].cause.b_timeout) begin
              rsp.b_valid <= 1'b1;
              rsp.b_id    <= pats[first + kb].resp_id;
              req.b_ready <= 1'b1;
              @(posedge clk);
              rsp.b_valid <= 1'b0;
              req.b_ready <= 1'b0;
            end
          end
        end
      end
    join
  endtask

  initial begin
    int       fd;
    int       code;
    int       id, len, awd, wd, bd, rid;
    int       first, n, gap, base, max_cyc;
    string    line;
    string    name;
    pattern_t p;
    rst_n        = 1'b0;
    reset_clear  = 1'b0;
    req          = '0;
    rsp          = '0;
    budget.aw_budget     = 12'd4;
    budget.w_unit_budget = 12'd3;
    budget.b_budget      = 12'd4;
    aw_done      = '0;
    w_done       = '0;
    lfsr         = 32'hfbab5139;
    limit_cycles = 0;
    max_cyc      = 0;

    fd = $fopen("write_guard_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file write_guard_patterns.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%h %h %h %h %h %h %s", id, len, awd, wd, bd, rid, name);
      if (code != 7) begin
        $display("Malformed pattern line: %s", line);
        abort_run();
      end
      p.id       = txn_id_t'(id);
      p.len      = burst_len_t'(len);
      p.aw_delay = awd[7:0];
      p.w_delay  = wd[7:0];
      p.b_delay  = bd[7:0];
      p.resp_id  = txn_id_t'(rid);
      p.cause    = cause_from_name(name);
      if (name != "none" && p.cause == '0) begin
        $display("Unknown fault cause %s in the pattern file", name);
        abort_run();
      end
      pats.push_back(p);
      if (awd + wd + bd > max_cyc) max_cyc = awd + wd + bd;
    end
    $fclose(fd);
    limit_cycles = pats.size() * (max_cyc + 120) + 200;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet bus for a dozen ticks
    repeat (48) @(posedge clk);
    @(negedge clk);
    check_value("irq_o pulses", irq_total, 0);
    check_value("reset_req_o", reset_req, 0);
    check_value("fault_o", fault, 0);

    first = 0;
    while (first < pats.size()) begin
      n = 1;
      if (pats[first].cause == '0) begin
        while (n < GROUP_MAX && first + n < pats.size() && pats[first + n].cause == '0) n++;
      end
      base = irq_total;
      run_group(first, n);
      if (pats[first].cause == '0) begin
        repeat (2) @(negedge clk);
        check_value("irq_o pulses", irq_total - base, 0);
        check_value("reset_req_o", reset_req, 0);
        check_value("fault_o", fault, pats[first].cause);
      end else begin
        for (int c = 0; c < 64 && !reset_req; c++) @(negedge clk);
        repeat (4) @(negedge clk);
        check_value("irq_o pulses", irq_total - base, 1);
        check_value("reset_req_o", reset_req, 1);
        check_value("fault_o", fault, pats[first].cause);
      end
      gap = 0;
      for (int b = 0; b < 3; b++) begin
        lfsr = lfsr_step(lfsr);
        gap  = (gap << 1) | lfsr[0];
      end
      repeat (gap) @(posedge clk);
      if (pats[first].cause != '0) begin
        @(negedge clk);
        check_value("reset_req_o", reset_req, 1);
        @(posedge clk);
        reset_clear <= 1'b1;
        @(posedge clk);
        reset_clear <= 1'b0;
        @(negedge clk);
        check_value("reset_req_o", reset_req, 0);
        check_value("fault_o", fault, 0);
      end
      first += n;
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the pattern run did not finish in %0d cycles", limit_cycles);
    abort_run();
  end

endmodule

// ==== write_guard_patterns.txt ====
# id len aw_dly w_dly b_dly resp_id cause   (hex fields, delays in clocks)
# aw_dly ff sends only a B with resp_id; cause is none, aw, w, b or unwanted
3 02 01 03 01 3 none
5 03 02 04 02 5 none
a 02 00 03 01 a none
1 00 01 02 01 1 none
6 00 18 02 01 6 aw
2 01 02 03 02 2 none
7 00 01 18 01 7 w
7 03 01 18 01 7 none
4 01 02 20 01 4 w
8 01 01 02 18 8 b
9 01 01 02 01 c unwanted
0 00 ff 00 02 b unwanted
c 02 03 04 02 c none
d 03 01 03 01 d none
e 02 02 04 02 e none
f 01 01 02 08 f none

// ==== src.f ====
write_guard_pkg.sv
tick_prescaler.sv
txn_slot.sv
txn_tracker.sv
fault_reporter.sv
write_guard.sv
tb_write_guard.sv
